//--- list.f
+incdir+rtl
+incdir+bench
rtl/tawas_isa_pkg.sv
rtl/tawas_core_pkg.sv
rtl/au_rf_if.sv
rtl/ls_rf_if.sv
rtl/tawas_fetch.sv
rtl/tawas_regfile.sv
rtl/tawas_au.sv
rtl/tawas_ls.sv
rtl/tawas_core.sv
bench/tawas_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tawas_core_tb -f list.f -o tawas_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tawas_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
exit 0

//--- bench/tawas_tb_prog.svh
`ifndef TAWAS_TB_PROG_SVH
`define TAWAS_TB_PROG_SVH

// Thread 3 runs longest: 3 setup, 5 loop passes of 4, the exit branch and 2 stores
localparam int LONGEST_THREAD_INSTRS = 26;

// Store requests issued by all four threads together
localparam int N_STORES = 19;

// Columns: byte address in the upper word, expected data in the lower word
localparam int N_EXPECTED = 18;
localparam logic [63:0] EXPECTED [N_EXPECTED] = '{
  {32'h0000_0040, 32'h0000_1234},
  {32'h0000_0044, 32'hFFFF_A143},
  {32'h0000_0048, 32'h0000_8325},
  {32'h0000_004C, 32'h0000_0204},
  {32'h0000_0050, 32'hFFFF_9F3F},
  {32'h0000_0054, 32'hFFFF_9D3B},
  {32'h0000_0058, 32'hD00D_E916},
  {32'h0000_0100, 32'h0000_0F35},
  {32'h0000_0104, 32'h0000_F350},
  {32'h0000_0108, 32'h0FFF_F800},
  {32'h0000_010C, 32'h0000_0F25},
  {32'h0000_0110, 32'hFFFF_FF35},
  {32'h0000_0238, 32'h89AB_CDF0},
  {32'h0000_0240, 32'h89AB_CDEF},
  {32'h0000_0248, 32'h89AB_CDF0},
  {32'h0000_0300, 32'h0000_0005},
  {32'h0000_0304, 32'h0000_0000},
  {32'h0000_03F0, 32'hE7C6_5AA5}
};

task automatic load_programs();
  int loop_pc;
  // Thread 0 runs ADD, SUB, AND, OR and XOR on 0x1234 and a negative MOVI value
  place(0);
  emit(alu_word(MOVI, 7, 0, 0, 'h0040));
  emit(alu_word(MOVI, 1, 0, 0, 'h1234));
  emit(alu_word(MOVI, 2, 0, 0, 'h8F0F));
  emit(alu_word(ADD, 3, 1, 2, 0));
  emit(mem_word(STW, 1, 7, 0));
  emit(mem_word(STW, 3, 7, 4));
  emit(alu_word(SUB, 3, 1, 2, 0));
  emit(mem_word(STW, 3, 7, 8));
  emit(alu_word(AND, 3, 1, 2, 0));
  emit(mem_word(STW, 3, 7, 12));
  emit(alu_word(OR, 3, 1, 2, 0));
  emit(mem_word(STW, 3, 7, 16));
  emit(alu_word(XOR, 3, 1, 2, 0));
  emit(mem_word(STW, 3, 7, 20));
  // Byte lanes 0 and 2 of the shared word
  emit(alu_word(MOVI, 4, 0, 0, 'h00A5));
  emit(mem_word(STB, 4, 0, 'h3F0));
  emit(alu_word(MOVI, 4, 0, 0, 'h7FC6));
  emit(mem_word(STB, 4, 0, 'h3F2));
  park();

  // Thread 1: a shift count of 36 must act as 4
  place(1);
  emit(alu_word(MOVI, 7, 0, 0, 'h0100));
  emit(alu_word(MOVI, 1, 0, 0, 'h0F35));
  emit(alu_word(MOVI, 2, 0, 0, 36));
  emit(alu_word(SHL, 3, 1, 2, 0));
  emit(mem_word(STW, 1, 7, 0));
  emit(mem_word(STW, 3, 7, 4));
  emit(alu_word(MOVI, 4, 0, 0, 'h8000));
  emit(alu_word(SHR, 5, 4, 2, 0));
  emit(mem_word(STW, 5, 7, 8));
  emit(alu_word(ADDI, 6, 1, 0, -16));
  emit(mem_word(STW, 6, 7, 12));
  emit(alu_word(ADDI, 3, 1, 0, -4096));
  emit(mem_word(STW, 3, 7, 16));
  park();

  // Thread 2 uses the loaded word in the very next instruction
  place(2);
  emit(alu_word(MOVI, 7, 0, 0, 'h0240));
  emit(mem_word(LDW, 1, 7, 0));
  emit(alu_word(ADDI, 1, 1, 0, 1));
  emit(mem_word(STW, 1, 7, 8));
  emit(mem_word(STW, 1, 7, -8));
  // Byte lanes 1 and 3 of the shared word
  emit(alu_word(MOVI, 4, 0, 0, 'h005A));
  emit(mem_word(STB, 4, 0, 'h3F1));
  emit(alu_word(MOVI, 4, 0, 0, 'h12E7));
  emit(mem_word(STB, 4, 0, 'h3F3));
  park();

  // Thread 3 counts r1 down from five and counts the passes in r2
  place(3);
  emit(alu_word(MOVI, 7, 0, 0, 'h0300));
  emit(alu_word(MOVI, 1, 0, 0, 5));
  emit(alu_word(MOVI, 2, 0, 0, 0));
  loop_pc = fill_ptr;
  emit(mem_word(BEQZ, 1, 0, 4));
  emit(alu_word(ADDI, 1, 1, 0, -1));
  emit(alu_word(ADDI, 2, 2, 0, 1));
  emit(mem_word(JMP, 0, 0, loop_pc));
  emit(mem_word(STW, 2, 7, 0));
  emit(mem_word(STW, 1, 7, 4));
  park();
endtask

`endif

//--- bench/tawas_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tawas_defines.svh"

module tawas_core_tb
  import tawas_isa_pkg::*;
();

  logic        clk;
  logic        arst_n;
  logic [31:0] idata = 32'h0;
  logic [31:0] din = 32'h0;
  logic        ics;
  logic [23:0] iaddr;
  logic        dcs;
  logic        dwr;
  logic [31:0] daddr;
  logic [3:0]  dmask;
  logic [31:0] dout;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];

  // Requests seen in the middle of a cycle, answered after the next edge
  logic        i_pend = 1'b0;
  logic [7:0]  i_addr = 8'h0;
  logic        d_pend = 1'b0;
  logic [7:0]  d_addr = 8'h0;

  int fill_ptr = 0;
  int store_count = 0;
  int cycles = 0;
  int checks = 0;
  int errors = 0;

  function automatic logic [31:0] alu_word(alu_op_e op, int rc, int ra, int rb, int imm);
    return {1'b0, op, 3'(rc), 3'(ra), 3'(rb), 2'b00, 16'(imm)};
  endfunction

  function automatic logic [31:0] mem_word(mem_op_e op, int rd, int rp, int field);
    return {1'b1, op, 3'(rd), 3'(rp), 22'(field)};
  endfunction

  task automatic place(int thread);
    fill_ptr = thread * `TAWAS_PC_STRIDE;
  endtask

  task automatic emit(logic [31:0] word);
    imem[8'(fill_ptr)] = word;
    fill_ptr++;
  endtask

  // A finished thread spins on a jump to itself
  task automatic park();
    emit(mem_word(JMP, 0, 0, fill_ptr));
  endtask

  `include "tawas_tb_prog.svh"

  localparam int TIMEOUT_CYCLES = 4 * LONGEST_THREAD_INSTRS + 64;

  task automatic check_value(string what, logic [31:0] got, logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  tawas_core tawas_core_inst (
    .CLK    (clk),
    .arst_n (arst_n),
    .ics    (ics),
    .iaddr  (iaddr),
    .idata  (idata),
    .dcs    (dcs),
    .dwr    (dwr),
    .daddr  (daddr),
    .dmask  (dmask),
    .dout   (dout),
    .din    (din)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20;
      clk = ~clk;
    end
  end

  // Stores land here and read requests are queued for the next edge
  always @(negedge clk) begin
    i_pend = ics;
    i_addr = iaddr[7:0];
    d_pend = dcs && !dwr;
    d_addr = daddr[9:2];
    if (dcs && (daddr[31:10] != 22'h0)) begin
      errors++;
      $display("Data access at %0t outside the 1 KiB memory, address %h", $time, daddr);
    end
    if (dcs && dwr) begin
      for (int b = 0; b < 4; b++) begin
        if (dmask[b]) begin
          dmem[daddr[9:2]][8*b +: 8] = dout[8*b +: 8];
        end
      end
      store_count++;
    end
  end

  // Both memories answer one cycle after the request
  always @(posedge clk) begin
    #2;
    idata = i_pend ? imem[i_addr] : 32'h0;
    din   = d_pend ? dmem[d_addr] : 32'h0;
  end

  always @(posedge clk) begin
    if (arst_n) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        errors++;
        $display("Timeout: %0d of %0d stores seen after %0d cycles",
                 store_count, N_STORES, cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("** FAIL **");
        $finish;
      end
    end
  end

  initial begin
    logic [31:0] addr;
    arst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0;
      dmem[i] = {16'hD00D, ~8'(i), 8'(i)};
    end
    // Load source for thread 2 and the word shared by the byte stores
    dmem[8'h90] = 32'h89AB_CDEF;
    dmem[8'hFC] = 32'h1122_3344;
    load_programs();

    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;

    wait (store_count == N_STORES);
    // Parked threads must not issue any further store
    repeat (16) @(posedge clk);
    check_value("store count", 32'(store_count), 32'(N_STORES));

    for (int k = 0; k < N_EXPECTED; k++) begin
      addr = EXPECTED[k][63:32];
      check_value($sformatf("word at %h", addr), dmem[addr[9:2]], EXPECTED[k][31:0]);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/tawas_core.sv
`timescale 1ns/1ps
`default_nettype none

module tawas_core
  import tawas_core_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        arst_n,

  output logic             ics,
  output logic [23:0]      iaddr,
  input  wire logic [31:0] idata,

  output logic             dcs,
  output logic             dwr,
  output logic [31:0]      daddr,
  output logic [3:0]       dmask,
  output logic [31:0]      dout,
  input  wire logic [31:0] din
);

  slice_t      slice;
  logic        au_cmd_vld;
  au_cmd_t     au_cmd;
  logic        ls_cmd_vld;
  ls_cmd_t     ls_cmd;
  logic        br_taken;
  logic [23:0] br_target;

  au_rf_if au_rf ();
  ls_rf_if ls_rf ();

  tawas_fetch tawas_fetch (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .ics        (ics),
    .iaddr      (iaddr),
    .idata      (idata),
    .slice      (slice),
    .br_taken   (br_taken),
    .br_target  (br_target),
    .au_cmd_vld (au_cmd_vld),
    .au_cmd     (au_cmd),
    .ls_cmd_vld (ls_cmd_vld),
    .ls_cmd     (ls_cmd)
  );

  tawas_regfile tawas_regfile (
    .CLK    (CLK),
    .arst_n (arst_n),
    .slice  (slice),
    .au_rf  (au_rf.rf),
    .ls_rf  (ls_rf.rf)
  );

  tawas_au tawas_au (
    .slice      (slice),
    .au_cmd_vld (au_cmd_vld),
    .au_cmd     (au_cmd),
    .au_rf      (au_rf.au),
    .br_taken   (br_taken),
    .br_target  (br_target)
  );

  tawas_ls tawas_ls (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .slice      (slice),
    .ls_cmd_vld (ls_cmd_vld),
    .ls_cmd     (ls_cmd),
    .ls_rf      (ls_rf.ls),
    .dcs        (dcs),
    .dwr        (dwr),
    .daddr      (daddr),
    .dmask      (dmask),
    .dout       (dout),
    .din        (din)
  );

endmodule

`default_nettype wire

//--- rtl/tawas_ls.sv
`timescale 1ns/1ps
`default_nettype none

`include "tawas_defines.svh"

module tawas_ls
  import tawas_core_pkg::*;
(
  input  wire logic                     CLK,
  input  wire logic                     arst_n,

  input  slice_t                        slice,
  input  wire logic                     ls_cmd_vld,
  input  ls_cmd_t                       ls_cmd,

  ls_rf_if.ls                           ls_rf,

  output logic                          dcs,
  output logic                          dwr,
  output logic [31:0]                   daddr,
  output logic [3:0]                    dmask,
  output logic [`TAWAS_DATA_W-1:0]      dout,
  input  wire logic [`TAWAS_DATA_W-1:0] din
);

  logic [31:0] addr;
  slice_t      req_slice;
  reg_sel_t    req_sel;

  assign ls_rf.ptr_sel   = ls_cmd.rp;
  assign ls_rf.store_sel = ls_cmd.rd;

  // Byte address is pointer plus signed offset
  assign addr = ls_rf.ptr + ls_cmd.off;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dcs <= 1'b0;
      dwr <= 1'b0;
    end else begin
      dcs <= ls_cmd_vld;
      dwr <= ls_cmd_vld && ls_cmd.store;
    end
  end

  // Request payload and the writeback target that goes with it
  always_ff @(posedge CLK) begin
    if (ls_cmd_vld) begin
      daddr     <= addr;
      req_slice <= slice;
      req_sel   <= ls_cmd.rd;
      if (ls_cmd.byte_wr) begin
        // Byte stores hit one lane and copy the byte to every lane
        dmask <= 4'b0001 << addr[1:0];
        dout  <= {4{ls_rf.store[7:0]}};
      end else begin
        dmask <= 4'b1111;
        dout  <= ls_rf.store;
      end
    end
  end

  // Read data returns one cycle after the request
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ls_rf.load_vld <= 1'b0;
    end else begin
      ls_rf.load_vld <= dcs && !dwr;
    end
  end

  always_ff @(posedge CLK) begin
    ls_rf.load_slice <= req_slice;
    ls_rf.load_sel   <= req_sel;
  end

  assign ls_rf.load = din;

endmodule

`default_nettype wire

//--- rtl/tawas_au.sv
`timescale 1ns/1ps
`default_nettype none

`include "tawas_defines.svh"

module tawas_au
  import tawas_isa_pkg::*;
  import tawas_core_pkg::*;
(
  input  slice_t                    slice,

  input  wire logic                 au_cmd_vld,
  input  au_cmd_t                   au_cmd,

  au_rf_if.au                       au_rf,

  output logic                      br_taken,
  output logic [`TAWAS_IADDR_W-1:0] br_target
);

  logic [`TAWAS_DATA_W-1:0] result;
  logic [4:0]               shamt;

  assign au_rf.ra_sel = au_cmd.ra;
  assign au_rf.rb_sel = au_cmd.rb;

  // Shift count comes from the low five bits of rb
  assign shamt = au_rf.rb[4:0];

  always_comb begin
    case (au_cmd.op)
      ADD:     result = au_rf.ra + au_rf.rb;
      SUB:     result = au_rf.ra - au_rf.rb;
      AND:     result = au_rf.ra & au_rf.rb;
      OR:      result = au_rf.ra | au_rf.rb;
      XOR:     result = au_rf.ra ^ au_rf.rb;
      SHL:     result = au_rf.ra << shamt;
      SHR:     result = au_rf.ra >> shamt;
      ADDI:    result = au_rf.ra + au_cmd.imm;
      MOVI:    result = au_cmd.imm;
      default: result = '0;
    endcase
  end

  // Branch commands never write a register
  assign au_rf.rc_vld   = au_cmd_vld && !au_cmd.br;
  assign au_rf.rc_slice = slice;
  assign au_rf.rc_sel   = au_cmd.rc;
  assign au_rf.rc       = result;

  assign br_taken  = au_cmd_vld && au_cmd.br && (au_rf.ra == '0);
  assign br_target = au_cmd.pc + au_cmd.imm[`TAWAS_IADDR_W-1:0];

endmodule

`default_nettype wire

//--- rtl/tawas_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "tawas_defines.svh"

module tawas_regfile
  import tawas_core_pkg::*;
(
  input  wire logic CLK,
  input  wire logic arst_n,

  input  slice_t    slice,

  au_rf_if.rf       au_rf,
  ls_rf_if.rf       ls_rf
);

  // Thread number in the upper index bits, register number in the lower
  logic [`TAWAS_DATA_W-1:0] regs [`TAWAS_THREADS * `TAWAS_REGS];

  // All reads look at the thread in the execute slot
  assign au_rf.ra    = regs[{slice, au_rf.ra_sel}];
  assign au_rf.rb    = regs[{slice, au_rf.rb_sel}];
  assign ls_rf.ptr   = regs[{slice, ls_rf.ptr_sel}];
  assign ls_rf.store = regs[{slice, ls_rf.store_sel}];

  // The AU writes the execute thread while the load writes a thread two slots
  // behind it, so both writes can land in the same cycle
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `TAWAS_THREADS * `TAWAS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (au_rf.rc_vld) begin
        regs[{au_rf.rc_slice, au_rf.rc_sel}] <= au_rf.rc;
      end
      if (ls_rf.load_vld) begin
        regs[{ls_rf.load_slice, ls_rf.load_sel}] <= ls_rf.load;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/tawas_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "tawas_defines.svh"

module tawas_fetch
  import tawas_isa_pkg::*;
  import tawas_core_pkg::*;
(
  input  wire logic                      CLK,
  input  wire logic                      arst_n,

  output logic                           ics,
  output logic [`TAWAS_IADDR_W-1:0]      iaddr,
  input  wire logic [31:0]               idata,

  output slice_t                         slice,
  input  wire logic                      br_taken,
  input  wire logic [`TAWAS_IADDR_W-1:0] br_target,

  output logic                           au_cmd_vld,
  output au_cmd_t                        au_cmd,
  output logic                           ls_cmd_vld,
  output ls_cmd_t                        ls_cmd
);

  logic [`TAWAS_IADDR_W-1:0] pc [`TAWAS_THREADS];
  logic [`TAWAS_IADDR_W-1:0] pc_next;
  slice_t                    fetch_slice;
  slice_t                    exe_slice;
  logic                      exe_vld;
  logic                      is_mem;
  logic                      jmp;
  instr_u                    ins;

  // The fetch slice runs one cycle ahead of the execute slice
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ics         <= 1'b0;
      fetch_slice <= '0;
      exe_vld     <= 1'b0;
      exe_slice   <= '0;
    end else begin
      ics       <= 1'b1;
      exe_vld   <= ics;
      exe_slice <= fetch_slice;
      if (ics) begin
        fetch_slice <= fetch_slice + 1'b1;
      end
    end
  end

  assign iaddr = pc[fetch_slice];
  assign slice = exe_slice;

  assign ins    = instr_u'(idata[30:0]);
  assign is_mem = idata[31];
  assign jmp    = exe_vld && is_mem && (ins.mem.opcode == JMP);

  always_comb begin
    au_cmd.op  = ins.alu.opcode;
    au_cmd.rc  = ins.alu.rc;
    au_cmd.ra  = ins.alu.ra;
    au_cmd.rb  = ins.alu.rb;
    au_cmd.imm = {{16{ins.alu.imm[15]}}, ins.alu.imm};
    au_cmd.br  = 1'b0;
    au_cmd.pc  = pc[exe_slice];
    if (is_mem) begin
      // BEQZ tests the data register and adds a signed word displacement
      au_cmd.op  = ADD;
      au_cmd.rc  = ins.mem.rd;
      au_cmd.ra  = ins.mem.rd;
      au_cmd.rb  = ins.mem.rp;
      au_cmd.imm = {{10{ins.mem.field[21]}}, ins.mem.field};
      au_cmd.br  = 1'b1;
    end
    au_cmd_vld = exe_vld && (!is_mem || (ins.mem.opcode == BEQZ));
  end

  always_comb begin
    ls_cmd.store   = (ins.mem.opcode == STW) || (ins.mem.opcode == STB);
    ls_cmd.byte_wr = (ins.mem.opcode == STB);
    ls_cmd.rd      = ins.mem.rd;
    ls_cmd.rp      = ins.mem.rp;
    ls_cmd.off     = {{10{ins.mem.field[21]}}, ins.mem.field};
    ls_cmd_vld     = exe_vld && is_mem && (ins.mem.opcode inside {LDW, STW, STB});
  end

  // A jump target is absolute and zero extended
  always_comb begin
    if (jmp) begin
      pc_next = `TAWAS_IADDR_W'(ins.mem.field);
    end else if (br_taken) begin
      pc_next = br_target;
    end else begin
      pc_next = pc[exe_slice] + 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `TAWAS_THREADS; i++) begin
        pc[i] <= `TAWAS_IADDR_W'(i * `TAWAS_PC_STRIDE);
      end
    end else if (exe_vld) begin
      pc[exe_slice] <= pc_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ls_rf_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "tawas_defines.svh"

interface ls_rf_if
  import tawas_core_pkg::*;
();

  reg_sel_t                 ptr_sel;
  reg_sel_t                 store_sel;
  logic [`TAWAS_DATA_W-1:0] ptr;
  logic [`TAWAS_DATA_W-1:0] store;

  // Load writeback goes to its own thread, not the execute slice
  logic                     load_vld;
  slice_t                   load_slice;
  reg_sel_t                 load_sel;
  logic [`TAWAS_DATA_W-1:0] load;

  modport ls (
    output ptr_sel, store_sel, load_vld, load_slice, load_sel, load,
    input  ptr, store
  );

  modport rf (
    input  ptr_sel, store_sel, load_vld, load_slice, load_sel, load,
    output ptr, store
  );

endinterface

`default_nettype wire

//--- rtl/au_rf_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "tawas_defines.svh"

interface au_rf_if
  import tawas_core_pkg::*;
();

  reg_sel_t                 ra_sel;
  reg_sel_t                 rb_sel;
  logic [`TAWAS_DATA_W-1:0] ra;
  logic [`TAWAS_DATA_W-1:0] rb;

  // Result write, taken on the next clock edge
  logic                     rc_vld;
  slice_t                   rc_slice;
  reg_sel_t                 rc_sel;
  logic [`TAWAS_DATA_W-1:0] rc;

  modport au (
    output ra_sel, rb_sel, rc_vld, rc_slice, rc_sel, rc,
    input  ra, rb
  );

  modport rf (
    input  ra_sel, rb_sel, rc_vld, rc_slice, rc_sel, rc,
    output ra, rb
  );

endinterface

`default_nettype wire

//--- rtl/tawas_core_pkg.sv
`default_nettype none

package tawas_core_pkg;

  import tawas_isa_pkg::*;

  `include "tawas_defines.svh"

  typedef logic [1:0] slice_t;
  typedef logic [2:0] reg_sel_t;

  // Branches travel as arithmetic commands so the AU can test the register
  typedef struct packed {
    alu_op_e                   op;
    reg_sel_t                  rc;
    reg_sel_t                  ra;
    reg_sel_t                  rb;
    logic [`TAWAS_DATA_W-1:0]  imm;
    logic                      br;
    logic [`TAWAS_IADDR_W-1:0] pc;
  } au_cmd_t;

  typedef struct packed {
    logic                     store;
    logic                     byte_wr;
    reg_sel_t                 rd;
    reg_sel_t                 rp;
    logic [`TAWAS_DATA_W-1:0] off;
  } ls_cmd_t;

endpackage

`default_nettype wire

//--- rtl/tawas_isa_pkg.sv
`default_nettype none

package tawas_isa_pkg;

  // Arithmetic opcodes, used when bit 31 of the word is clear
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SHL  = 4'd5,
    SHR  = 4'd6,
    ADDI = 4'd7,
    MOVI = 4'd8
  } alu_op_e;

  // Memory and control opcodes, used when bit 31 of the word is set
  typedef enum logic [2:0] {
    LDW  = 3'd0,
    STW  = 3'd1,
    STB  = 3'd2,
    BEQZ = 3'd3,
    JMP  = 3'd4
  } mem_op_e;

  typedef struct packed {
    alu_op_e     opcode;
    logic [2:0]  rc;
    logic [2:0]  ra;
    logic [2:0]  rb;
    logic [1:0]  rsvd;
    logic [15:0] imm;
  } alu_fmt_t;

  // The 22-bit field is a byte offset, a word displacement or a jump target
  typedef struct packed {
    mem_op_e     opcode;
    logic [2:0]  rd;
    logic [2:0]  rp;
    logic [21:0] field;
  } mem_fmt_t;

  // Low 31 bits of an instruction word, read in either format
  typedef union packed {
    alu_fmt_t alu;
    mem_fmt_t mem;
  } instr_u;

endpackage

`default_nettype wire

//--- rtl/tawas_defines.svh
`ifndef TAWAS_DEFINES_SVH
`define TAWAS_DEFINES_SVH

// Thread count and the per-thread register window
`define TAWAS_THREADS 4
`define TAWAS_REGS 8

// Datapath word width
`define TAWAS_DATA_W 32

// Instruction address width, in words
`define TAWAS_IADDR_W 24

// Thread s starts fetching at word address s * stride
`define TAWAS_PC_STRIDE 64

`endif
